// File: common/pipePkg.sv
package pipePkg;

    // Data path width and register index width
    localparam int XLEN = 32;
    localparam int REG_BITS = 5;
    localparam int NUM_REGS = 2 ** REG_BITS;

    // Data memory is word addressed through byte address bits 7 to 2
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_IDX_BITS = $clog2(DMEM_WORDS);

    // The canonical nop is addi x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

    // Major opcodes of the supported subset
    localparam logic [6:0] OP_RTYPE = 7'b0110011;
    localparam logic [6:0] OP_ITYPE = 7'b0010011;
    localparam logic [6:0] OP_LOAD = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // Arithmetic funct3 values
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct3 of lw and sw, and of beq
    localparam logic [2:0] F3_WORD = 3'b010;
    localparam logic [2:0] F3_BEQ = 3'b000;

    // funct7 that turns add into sub
    localparam logic [6:0] F7_SUB = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } aluOpT;

    // Operand source for the execute stage
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_WB = 2'b01,
        FWD_MEM = 2'b10
    } fwdSelT;

endpackage

// File: design/fetchStage.sv
`timescale 1ns/1ps

module fetchStage import pipePkg::*; (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic branchTaken,
    input logic [XLEN-1:0] branchTarget,
    output logic [XLEN-1:0] imemAddr,
    input logic [31:0] imemData,
    output logic [31:0] instrD,
    output logic [XLEN-1:0] pcD
);

    logic [XLEN-1:0] pc;

    // Instruction memory is read straight from the current PC
    assign imemAddr = pc;

    // A redirect from execute wins over the load-use hold
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (!stall) begin
            pc <= pc + XLEN'(4);
        end
    end

    // The instruction word decides whether decode sees a bubble
    // A squashed fetch becomes a nop, which decodes to no enables
    always_ff @(posedge clk) begin
        if (rst || branchTaken) begin
            instrD <= NOP_INSTR;
        end else if (!stall) begin
            instrD <= imemData;
        end
    end

    // The pc travels with the word and only matters for branches
    always_ff @(posedge clk) begin
        if (!stall) begin
            pcD <= pc;
        end
    end

endmodule

// File: decode/regFile.sv
`timescale 1ns/1ps

module regFile import pipePkg::*; (
    input logic clk,
    input logic rst,
    input logic [REG_BITS-1:0] rs1D,
    input logic [REG_BITS-1:0] rs2D,
    output logic [XLEN-1:0] rdata1D,
    output logic [XLEN-1:0] rdata2D,
    input logic regWriteW,
    input logic [REG_BITS-1:0] rdW,
    input logic [XLEN-1:0] resultW
);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic writeLive;

    // A write to x0 is dropped here, so x0 stays at its reset value of zero
    assign writeLive = regWriteW && (rdW != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeLive) begin
            regs[rdW] <= resultW;
        end
    end

    // Writeback and decode share a cycle, so decode sees the value being written
    assign rdata1D = (writeLive && (rdW == rs1D)) ? resultW : regs[rs1D];
    assign rdata2D = (writeLive && (rdW == rs2D)) ? resultW : regs[rs2D];

endmodule

// File: decode/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import pipePkg::*; (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic flush,
    input logic [31:0] instrD,
    input logic [XLEN-1:0] pcD,
    output logic [REG_BITS-1:0] rs1D,
    output logic [REG_BITS-1:0] rs2D,
    input logic [XLEN-1:0] rdata1D,
    input logic [XLEN-1:0] rdata2D,
    output logic regWriteE,
    output logic memReadE,
    output logic memWriteE,
    output logic branchE,
    output logic aluSrcE,
    output aluOpT aluOpE,
    output logic [REG_BITS-1:0] rdE,
    output logic [REG_BITS-1:0] rs1E,
    output logic [REG_BITS-1:0] rs2E,
    output logic [XLEN-1:0] srcAE,
    output logic [XLEN-1:0] srcBE,
    output logic [XLEN-1:0] immE,
    output logic [XLEN-1:0] pcE
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immS;
    logic [XLEN-1:0] immB;
    logic [XLEN-1:0] immD;
    logic validD;
    logic usesRs2D;
    logic regWriteD;
    logic memReadD;
    logic memWriteD;
    logic branchD;
    logic aluSrcD;
    aluOpT aluOpD;

    assign opcode = instrD[6:0];
    assign funct3 = instrD[14:12];
    assign funct7 = instrD[31:25];

    // Sign extended immediates for the I, S and B formats
    assign immI = {{(XLEN-12){instrD[31]}}, instrD[31:20]};
    assign immS = {{(XLEN-12){instrD[31]}}, instrD[31:25], instrD[11:7]};
    assign immB = {{(XLEN-13){instrD[31]}}, instrD[31], instrD[7], instrD[30:25],
                   instrD[11:8], 1'b0};

    // Unused source fields read as x0 so they never trigger a false load-use stall
    assign rs1D = validD ? instrD[19:15] : '0;
    assign rs2D = (validD && usesRs2D) ? instrD[24:20] : '0;

    always_comb begin
        validD = 1'b0;
        usesRs2D = 1'b0;
        regWriteD = 1'b0;
        memReadD = 1'b0;
        memWriteD = 1'b0;
        branchD = 1'b0;
        aluSrcD = 1'b0;
        aluOpD = ALU_ADD;
        immD = immI;
        case (opcode)
            OP_RTYPE: begin
                validD = 1'b1;
                usesRs2D = 1'b1;
                regWriteD = 1'b1;
                // Shifts and sltu fall to the default and become a bubble
                case (funct3)
                    F3_ADD: aluOpD = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_SLT: aluOpD = ALU_SLT;
                    F3_XOR: aluOpD = ALU_XOR;
                    F3_OR: aluOpD = ALU_OR;
                    F3_AND: aluOpD = ALU_AND;
                    default: validD = 1'b0;
                endcase
            end
            OP_ITYPE: begin
                // Only addi is part of the subset
                validD = (funct3 == F3_ADD);
                regWriteD = 1'b1;
                aluSrcD = 1'b1;
            end
            OP_LOAD: begin
                validD = (funct3 == F3_WORD);
                regWriteD = 1'b1;
                memReadD = 1'b1;
                aluSrcD = 1'b1;
            end
            OP_STORE: begin
                validD = (funct3 == F3_WORD);
                usesRs2D = 1'b1;
                memWriteD = 1'b1;
                aluSrcD = 1'b1;
                immD = immS;
            end
            OP_BRANCH: begin
                // beq compares its sources in execute and leaves the ALU result unused
                validD = (funct3 == F3_BEQ);
                usesRs2D = 1'b1;
                branchD = 1'b1;
                immD = immB;
            end
            default: validD = 1'b0;
        endcase
    end

    // Control half of the decode to execute register
    // Flush or an undecodable word leaves every enable low
    always_ff @(posedge clk) begin
        if (rst || flush || !validD) begin
            regWriteE <= 1'b0;
            memReadE <= 1'b0;
            memWriteE <= 1'b0;
            branchE <= 1'b0;
            rdE <= '0;
        end else begin
            regWriteE <= regWriteD;
            memReadE <= memReadD;
            memWriteE <= memWriteD;
            branchE <= branchD;
            rdE <= instrD[11:7];
        end
    end

    // Operand half keeps its old contents behind a load-use bubble
    always_ff @(posedge clk) begin
        if (!stall) begin
            aluSrcE <= aluSrcD;
            aluOpE <= aluOpD;
            rs1E <= rs1D;
            rs2E <= rs2D;
            srcAE <= rdata1D;
            srcBE <= rdata2D;
            immE <= immD;
            pcE <= pcD;
        end
    end

endmodule

// File: execute/executeStage.sv
`timescale 1ns/1ps

module executeStage import pipePkg::*; (
    input logic clk,
    input logic rst,
    input logic regWriteE,
    input logic memReadE,
    input logic memWriteE,
    input logic branchE,
    input logic aluSrcE,
    input aluOpT aluOpE,
    input logic [REG_BITS-1:0] rdE,
    input logic [XLEN-1:0] srcAE,
    input logic [XLEN-1:0] srcBE,
    input logic [XLEN-1:0] immE,
    input logic [XLEN-1:0] pcE,
    input fwdSelT forwardAE,
    input fwdSelT forwardBE,
    input logic [XLEN-1:0] resultW,
    output logic branchTaken,
    output logic [XLEN-1:0] branchTarget,
    output logic [XLEN-1:0] aluResultM,
    output logic [XLEN-1:0] writeDataM,
    output logic [REG_BITS-1:0] rdM,
    output logic regWriteM,
    output logic memReadM,
    output logic memWriteM
);

    logic [XLEN-1:0] fwdA;
    logic [XLEN-1:0] fwdB;
    logic [XLEN-1:0] aluB;
    logic [XLEN-1:0] aluResultE;

    // Memory stage holds the younger result, writeback the older one
    always_comb begin
        case (forwardAE)
            FWD_MEM: fwdA = aluResultM;
            FWD_WB: fwdA = resultW;
            default: fwdA = srcAE;
        endcase
    end

    always_comb begin
        case (forwardBE)
            FWD_MEM: fwdB = aluResultM;
            FWD_WB: fwdB = resultW;
            default: fwdB = srcBE;
        endcase
    end

    // Loads, stores and addi take the immediate as the second operand
    assign aluB = aluSrcE ? immE : fwdB;

    always_comb begin
        case (aluOpE)
            ALU_ADD: aluResultE = fwdA + aluB;
            ALU_SUB: aluResultE = fwdA - aluB;
            ALU_AND: aluResultE = fwdA & aluB;
            ALU_OR: aluResultE = fwdA | aluB;
            ALU_XOR: aluResultE = fwdA ^ aluB;
            // slt compares as signed
            ALU_SLT: aluResultE = {{(XLEN-1){1'b0}}, $signed(fwdA) < $signed(aluB)};
            default: aluResultE = '0;
        endcase
    end

    // Branches are predicted not taken, so a taken beq redirects fetch from here
    assign branchTaken = branchE && (fwdA == fwdB);
    assign branchTarget = pcE + immE;

    // Enables and destination of the execute to memory register
    always_ff @(posedge clk) begin
        if (rst) begin
            regWriteM <= 1'b0;
            memReadM <= 1'b0;
            memWriteM <= 1'b0;
            rdM <= '0;
        end else begin
            regWriteM <= regWriteE;
            memReadM <= memReadE;
            memWriteM <= memWriteE;
            rdM <= rdE;
        end
    end

    // Store data is the forwarded rs2 value, not the stale register read
    always_ff @(posedge clk) begin
        aluResultM <= aluResultE;
        writeDataM <= fwdB;
    end

endmodule

// File: design/memoryStage.sv
`timescale 1ns/1ps

module memoryStage import pipePkg::*; (
    input logic clk,
    input logic rst,
    input logic [XLEN-1:0] aluResultM,
    input logic [XLEN-1:0] writeDataM,
    input logic [REG_BITS-1:0] rdM,
    input logic regWriteM,
    input logic memReadM,
    input logic memWriteM,
    output logic [REG_BITS-1:0] rdW,
    output logic regWriteW,
    output logic [XLEN-1:0] resultW,
    output logic wbValid,
    output logic [REG_BITS-1:0] wbRd,
    output logic [XLEN-1:0] wbData
);

    logic [XLEN-1:0] dmem [DMEM_WORDS];
    logic [DMEM_IDX_BITS-1:0] wordIdx;
    logic [XLEN-1:0] readDataM;

    // Byte address bits above the word offset pick the word
    assign wordIdx = aluResultM[DMEM_IDX_BITS+1:2];
    assign readDataM = dmem[wordIdx];

    // Memory starts out zeroed so every program sees the same contents
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (memWriteM) begin
            dmem[wordIdx] <= writeDataM;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            regWriteW <= 1'b0;
            rdW <= '0;
        end else begin
            regWriteW <= regWriteM;
            rdW <= rdM;
        end
    end

    // Result is chosen before the register, so writeback needs no mux
    always_ff @(posedge clk) begin
        resultW <= memReadM ? readDataM : aluResultM;
    end

    // Only writes to a real register count as retired writes
    assign wbValid = regWriteW && (rdW != '0);
    assign wbRd = rdW;
    assign wbData = resultW;

endmodule

// File: design/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit import pipePkg::*; (
    input logic [REG_BITS-1:0] rs1D,
    input logic [REG_BITS-1:0] rs2D,
    input logic [REG_BITS-1:0] rs1E,
    input logic [REG_BITS-1:0] rs2E,
    input logic [REG_BITS-1:0] rdE,
    input logic memReadE,
    input logic [REG_BITS-1:0] rdM,
    input logic regWriteM,
    input logic [REG_BITS-1:0] rdW,
    input logic regWriteW,
    input logic branchTaken,
    output fwdSelT forwardAE,
    output fwdSelT forwardBE,
    output logic stall,
    output logic flush
);

    logic memHitA;
    logic memHitB;
    logic wbHitA;
    logic wbHitB;

    // A destination of x0 never forwards since x0 always reads as zero
    assign memHitA = regWriteM && (rdM != '0) && (rdM == rs1E);
    assign memHitB = regWriteM && (rdM != '0) && (rdM == rs2E);
    assign wbHitA = regWriteW && (rdW != '0) && (rdW == rs1E);
    assign wbHitB = regWriteW && (rdW != '0) && (rdW == rs2E);

    // The memory stage is checked first because it holds the newer value
    assign forwardAE = memHitA ? FWD_MEM : (wbHitA ? FWD_WB : FWD_NONE);
    assign forwardBE = memHitB ? FWD_MEM : (wbHitB ? FWD_WB : FWD_NONE);

    // Load data only exists after the memory stage, so a direct consumer waits a cycle
    assign stall = memReadE && (rdE != '0) && ((rdE == rs1D) || (rdE == rs2D));

    // Both a stall and a taken branch put a bubble into execute
    assign flush = stall || branchTaken;

endmodule

// File: design/pipeCore.sv
`timescale 1ns/1ps

module pipeCore import pipePkg::*; (
    input logic clk,
    input logic rst,
    output logic [XLEN-1:0] imemAddr,
    input logic [31:0] imemData,
    output logic wbValid,
    output logic [REG_BITS-1:0] wbRd,
    output logic [XLEN-1:0] wbData
);

    // Fetch to decode
    logic [31:0] instrD;
    logic [XLEN-1:0] pcD;

    // Decode and register file
    logic [REG_BITS-1:0] rs1D;
    logic [REG_BITS-1:0] rs2D;
    logic [XLEN-1:0] rdata1D;
    logic [XLEN-1:0] rdata2D;

    // Execute stage inputs
    logic regWriteE;
    logic memReadE;
    logic memWriteE;
    logic branchE;
    logic aluSrcE;
    aluOpT aluOpE;
    logic [REG_BITS-1:0] rdE;
    logic [REG_BITS-1:0] rs1E;
    logic [REG_BITS-1:0] rs2E;
    logic [XLEN-1:0] srcAE;
    logic [XLEN-1:0] srcBE;
    logic [XLEN-1:0] immE;
    logic [XLEN-1:0] pcE;

    // Memory and writeback stages
    logic [XLEN-1:0] aluResultM;
    logic [XLEN-1:0] writeDataM;
    logic [REG_BITS-1:0] rdM;
    logic regWriteM;
    logic memReadM;
    logic memWriteM;
    logic [REG_BITS-1:0] rdW;
    logic regWriteW;
    logic [XLEN-1:0] resultW;

    // Hazard and redirect signals
    logic branchTaken;
    logic [XLEN-1:0] branchTarget;
    fwdSelT forwardAE;
    fwdSelT forwardBE;
    logic stall;
    logic flush;

    fetchStage uFetch (.clk, .rst, .stall, .branchTaken, .branchTarget, .imemAddr, .imemData,
                       .instrD, .pcD);

    decodeStage uDecode (.clk, .rst, .stall, .flush, .instrD, .pcD, .rs1D, .rs2D, .rdata1D,
                         .rdata2D, .regWriteE, .memReadE, .memWriteE, .branchE, .aluSrcE,
                         .aluOpE, .rdE, .rs1E, .rs2E, .srcAE, .srcBE, .immE, .pcE);

    regFile uRegFile (.clk, .rst, .rs1D, .rs2D, .rdata1D, .rdata2D, .regWriteW, .rdW,
                      .resultW);

    executeStage uExecute (.clk, .rst, .regWriteE, .memReadE, .memWriteE, .branchE, .aluSrcE,
                           .aluOpE, .rdE, .srcAE, .srcBE, .immE, .pcE, .forwardAE,
                           .forwardBE, .resultW, .branchTaken, .branchTarget, .aluResultM,
                           .writeDataM, .rdM, .regWriteM, .memReadM, .memWriteM);

    memoryStage uMemory (.clk, .rst, .aluResultM, .writeDataM, .rdM, .regWriteM, .memReadM,
                         .memWriteM, .rdW, .regWriteW, .resultW, .wbValid, .wbRd, .wbData);

    hazardUnit uHazard (.rs1D, .rs2D, .rs1E, .rs2E, .rdE, .memReadE, .rdM, .regWriteM, .rdW,
                        .regWriteW, .branchTaken, .forwardAE, .forwardBE, .stall, .flush);

endmodule

// File: test/retireChecker.sv
`timescale 1ns/1ps

module retireChecker import pipePkg::*; #(
    parameter int PROG_WORDS = 64
) (
    input logic clk,
    input logic rst,
    input logic start,
    input int testIndex,
    input logic [31:0] prog [PROG_WORDS],
    input logic wbValid,
    input logic [REG_BITS-1:0] wbRd,
    input logic [XLEN-1:0] wbData,
    output logic done,
    output int checkCount,
    output int errorCount
);

    // beq x0, x0, 0 marks the end of every program
    localparam logic [31:0] HALT_WORD = 32'h0000_0063;
    localparam int RETIRE_TIMEOUT = 200;
    localparam int IDLE_CYCLES = 24;

    logic [XLEN-1:0] modelRegs [NUM_REGS];
    logic [XLEN-1:0] modelMem [DMEM_WORDS];
    logic [REG_BITS-1:0] expRd [$];
    logic [XLEN-1:0] expData [$];

    initial begin
        done = 1'b0;
        checkCount = 0;
        errorCount = 0;
    end

    function automatic logic [XLEN-1:0] rtypeResult(input logic [2:0] f3, input logic [6:0] f7,
                                                    input logic [XLEN-1:0] a, b);
        case (f3)
            F3_ADD: return (f7 == F7_SUB) ? a - b : a + b;
            F3_SLT: return ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
            F3_XOR: return a ^ b;
            F3_OR: return a | b;
            F3_AND: return a & b;
            default: return '0;
        endcase
    endfunction

    // x0 is hardwired, so it neither changes nor retires
    task automatic recordWrite(input logic [REG_BITS-1:0] rd, input logic [XLEN-1:0] value);
        if (rd != '0) begin
            modelRegs[rd] = value;
            expRd.push_back(rd);
            expData.push_back(value);
        end
    endtask

    // Runs the program one instruction at a time from a cleared machine
    task automatic runModel();
        logic [31:0] instr;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] immI;
        logic [XLEN-1:0] immS;
        logic [XLEN-1:0] immB;
        logic [XLEN-1:0] addr;
        int pcIdx;
        expRd.delete();
        expData.delete();
        for (int i = 0; i < NUM_REGS; i++) modelRegs[i] = '0;
        for (int i = 0; i < DMEM_WORDS; i++) modelMem[i] = '0;
        pcIdx = 0;
        while (pcIdx < PROG_WORDS && prog[pcIdx] != HALT_WORD) begin
            instr = prog[pcIdx];
            a = modelRegs[instr[19:15]];
            b = modelRegs[instr[24:20]];
            immI = {{(XLEN-12){instr[31]}}, instr[31:20]};
            immS = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            immB = {{(XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            addr = a + ((instr[6:0] == OP_STORE) ? immS : immI);
            pcIdx++;
            case (instr[6:0])
                OP_RTYPE: recordWrite(instr[11:7], rtypeResult(instr[14:12], instr[31:25], a, b));
                OP_ITYPE: recordWrite(instr[11:7], a + immI);
                OP_LOAD: recordWrite(instr[11:7], modelMem[addr[7:2]]);
                OP_STORE: modelMem[addr[7:2]] = b;
                // Branch offsets count from the beq itself
                OP_BRANCH: if (a == b) pcIdx = pcIdx - 1 + int'(immB >> 2);
                default: ;
            endcase
        end
    endtask

    task automatic checkTest();
        int idx;
        int waited;
        int retired;
        int startErrors;
        startErrors = errorCount;
        retired = 0;
        runModel();
        // Retire events are sampled on the falling edge where they are stable
        for (idx = 0; idx < expRd.size(); idx++) begin
            waited = 0;
            @(negedge clk);
            while (!wbValid && waited < RETIRE_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!wbValid) begin
                $display("Test %0d timed out waiting for write %0d of %0d",
                         testIndex, idx + 1, expRd.size());
                errorCount++;
                break;
            end
            retired++;
            checkCount++;
            if (wbRd !== expRd[idx] || wbData !== expData[idx]) begin
                $display("Error at %0d ns: test %0d write %0d expected x%0d = %h, got x%0d = %h",
                         $time, testIndex, idx + 1, expRd[idx], expData[idx], wbRd, wbData);
                errorCount++;
            end
        end
        // The halt loop keeps squashing, so nothing more may retire
        for (waited = 0; waited < IDLE_CYCLES; waited++) begin
            @(negedge clk);
            if (wbValid) begin
                $display("Test %0d saw an extra write to x%0d after the last expected one",
                         testIndex, wbRd);
                errorCount++;
                retired++;
            end
        end
        $display("Test %0d: %0d writes expected, %0d retired, %0d errors",
                 testIndex, expRd.size(), retired, errorCount - startErrors);
        done <= 1'b1;
    endtask

    always @(posedge clk) begin
        if (start && !rst) begin
            done <= 1'b0;
            checkTest();
        end
    end

endmodule

// File: test/pipeTb.sv
`timescale 1ns/1ps

module pipeTb import pipePkg::*; ();

    localparam int PROG_WORDS = 64;
    localparam int NUM_TESTS = 12;
    localparam int NUM_CATEGORIES = 6;
    localparam int DONE_TIMEOUT = 12000;

    logic clk;
    logic rst;
    logic start;
    logic [XLEN-1:0] imemAddr;
    logic [31:0] imemData;
    logic wbValid;
    logic [REG_BITS-1:0] wbRd;
    logic [XLEN-1:0] wbData;
    logic checkDone;
    int checkCount;
    int errorCount;
    int testIndex;
    logic [31:0] lfsrState;
    logic [31:0] prog [PROG_WORDS];

    pipeCore dut (.clk, .rst, .imemAddr, .imemData, .wbValid, .wbRd, .wbData);

    retireChecker #(.PROG_WORDS(PROG_WORDS)) retireMon (.clk, .rst, .start, .testIndex, .prog,
        .wbValid, .wbRd, .wbData, .done(checkDone), .checkCount, .errorCount);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Instruction memory answers the address of the current cycle
    always @(negedge clk) begin
        imemData = prog[imemAddr[7:2]];
    end

    // Fibonacci form with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One step per bit and the new bit shifts in at the bottom
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, OP_RTYPE};
    endfunction

    function automatic logic [31:0] encodeI(input logic [6:0] op, input logic [2:0] f3,
                                            input logic [11:0] imm, input logic [4:0] rd, rs1);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encodeS(input logic [11:0] imm, input logic [4:0] rs1, rs2);
        return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] encodeB(input logic [12:0] imm, input logic [4:0] rs1, rs2);
        return {imm[12], imm[10:5], rs2, rs1, F3_BEQ, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    // Kinds are 0 register ALU, 1 addi, 2 lw, 3 sw and 4 beq
    function automatic int pickKind(input int category, input int roll);
        case (category)
            0, 1: return (roll < 9) ? 0 : 1;
            2: return (roll < 6) ? 2 : ((roll < 8) ? 3 : ((roll < 13) ? 0 : 1));
            3: return (roll < 5) ? 3 : ((roll < 10) ? 2 : ((roll < 13) ? 1 : 0));
            4: return (roll < 5) ? 4 : ((roll < 10) ? 0 : ((roll < 13) ? 1 : 2));
            default: return roll % 5;
        endcase
    endfunction

    task automatic buildProgram(input int category);
        int len;
        int kind;
        int skip;
        int addrBits;
        logic lastLoad;
        logic [4:0] lastRd;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [11:0] offset;
        len = 32 + int'(randBits(4));
        // Memory tests crowd into eight words so addresses collide
        addrBits = (category == 2 || category == 3) ? 3 : 6;
        lastLoad = 1'b0;
        lastRd = '0;
        for (int i = 0; i < len; i++) begin
            kind = pickKind(category, int'(randBits(4)));
            rd = 5'(randBits(3));
            rs1 = 5'(randBits(3));
            rs2 = 5'(randBits(3));
            offset = 12'(randBits(addrBits) << 2);
            // Writes to x0 and reads of x0 right after them
            if (category == 1 && randBits(1)) rd = '0;
            if (category == 1 && randBits(1)) rs1 = '0;
            // The word after a load consumes its result
            if (category == 2 && lastLoad) rs1 = lastRd;
            case (kind)
                0: begin
                    case (randBits(3))
                        1: prog[i] = encodeR(F7_SUB, F3_ADD, rd, rs1, rs2);
                        2: prog[i] = encodeR(7'd0, F3_AND, rd, rs1, rs2);
                        3: prog[i] = encodeR(7'd0, F3_OR, rd, rs1, rs2);
                        4: prog[i] = encodeR(7'd0, F3_XOR, rd, rs1, rs2);
                        5: prog[i] = encodeR(7'd0, F3_SLT, rd, rs1, rs2);
                        default: prog[i] = encodeR(7'd0, F3_ADD, rd, rs1, rs2);
                    endcase
                end
                1: prog[i] = encodeI(OP_ITYPE, F3_ADD, 12'(randBits(12)), rd, rs1);
                2: prog[i] = encodeI(OP_LOAD, F3_WORD, offset, rd, 5'd0);
                3: prog[i] = encodeS(offset, 5'd0, rs2);
                default: begin
                    // Equal sources half the time so many branches are taken
                    if (randBits(1)) rs2 = rs1;
                    skip = 1 + int'(randBits(5)) % (len - i);
                    prog[i] = encodeB(13'(4 * skip), rs1, rs2);
                end
            endcase
            lastLoad = (kind == 2);
            lastRd = rd;
        end
        // The halt spins on itself and everything past it is a numbered x0 write
        prog[len] = encodeB(13'd0, 5'd0, 5'd0);
        for (int i = len + 1; i < PROG_WORDS; i++) begin
            prog[i] = encodeI(OP_ITYPE, F3_ADD, 12'(i), 5'd0, 5'd0);
        end
    endtask

    initial begin
        int waited;
        int testsRun;
        logic timedOut;
        rst = 1'b1;
        start = 1'b0;
        imemData = '0;
        testIndex = 0;
        testsRun = 0;
        timedOut = 1'b0;
        lfsrState = 32'h203d;
        for (int t = 0; t < NUM_TESTS && !timedOut; t++) begin
            rst = 1'b1;
            testIndex = t;
            buildProgram(t % NUM_CATEGORIES);
            repeat (2) @(negedge clk);
            rst = 1'b0;
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            waited = 0;
            while (!checkDone && waited < DONE_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!checkDone) begin
                $display("Timed out waiting for the checker to finish test %0d", t);
                timedOut = 1'b1;
            end else begin
                testsRun++;
            end
        end
        $display("Ran %0d tests with %0d retire checks and %0d errors",
                 testsRun, checkCount, errorCount);
        if (!timedOut && errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: compile.f
common/pipePkg.sv
design/fetchStage.sv
decode/regFile.sv
decode/decodeStage.sv
execute/executeStage.sv
design/memoryStage.sv
design/hazardUnit.sv
design/pipeCore.sv
test/retireChecker.sv
test/pipeTb.sv
